/* logic/larvaPkg.sv */
`default_nettype none

package larvaPkg;

	////////////////////////////////////////////////////////////////////////////
	// Bus and payload widths

	typedef logic [31:0] word_t;      // APB data word
	typedef logic [7:0]  byte_t;      // UART character, PWM duty
	typedef logic [31:2] vector_t;    // Word address of a handler
	typedef logic [7:0]  ioAddr_t;    // Byte offset inside the I/O page
	typedef logic [2:0]  irqLines_t;  // 0 UART rx, 1 UART tx ready, 2 PWM

	// APB phase tracking
	typedef enum logic [1:0] {
		apbIdle,
		apbAccess,
		apbWait
	} apbState_t;

	////////////////////////////////////////////////////////////////////////////
	// Register map

	localparam ioAddr_t UART_DATA       = 8'h00;  // Tx on write, rx on read
	localparam ioAddr_t UART_STATUS     = 8'h04;
	localparam ioAddr_t PWM_DUTY        = 8'h20;
	localparam ioAddr_t TIMER           = 8'h60;  // Free-running count
	localparam ioAddr_t IRQ_ENABLE      = 8'hE0;
	localparam ioAddr_t IRQ_VECTOR_BASE = 8'hF0;  // Three vectors, one word apart

	// PWM counter length in clocks
	localparam word_t PWM_PERIOD = 32'd180;

	// Status word layout
	localparam int STAT_RX_VALID    = 0;
	localparam int STAT_TX_READY    = 1;
	localparam int STAT_FRAME_ERROR = 2;
	localparam int STAT_OVERRUN     = 3;
	localparam int STAT_PWM         = 4;

endpackage

`default_nettype wire

/* logic/uartIf.sv */
`timescale 1ns/100ps
`default_nettype none

interface uartIf;
	import larvaPkg::*;

	byte_t txData;      // Character to send
	logic  txWrite;     // One-cycle load strobe
	logic  txReady;     // Transmitter idle
	logic  rxRead;      // One-cycle flag clear
	byte_t rxData;      // Last character received
	logic  rxValid;
	logic  rxOverrun;
	logic  rxFrameError;

	// Register side
	modport ctrl (
		output txData, txWrite, rxRead,
		input  txReady, rxData, rxValid, rxOverrun, rxFrameError
	);

	modport tx (input txData, txWrite, output txReady);

	modport rx (input rxRead, output rxData, rxValid, rxOverrun, rxFrameError);

endinterface

`default_nettype wire

/* logic/apbRegisterControl.sv */
`timescale 1ns/100ps
`default_nettype none

module apbRegisterControl (
	input  logic                clk,
	input  logic                reset,
	input  logic                psel,
	input  logic                penable,
	input  logic                pwrite,
	input  larvaPkg::ioAddr_t   paddr,
	input  larvaPkg::word_t     pwdata,
	output larvaPkg::word_t     prdata,
	output logic                pready,
	uartIf.ctrl                 uart,
	input  logic                pwmIrq,
	output logic                dutyWrite,
	output logic                enableWrite,
	output logic                vectorWrite,
	output logic [1:0]          vectorIndex,
	output larvaPkg::word_t     wdata,
	input  larvaPkg::irqLines_t enable
);
	import larvaPkg::*;

	apbState_t state;
	apbState_t nextState;
	logic      accessPhase;   // psel and penable after a setup cycle
	logic      isUartData;
	logic      isVector;
	logic      stall;         // UART not ready, hold pready low
	logic      writeDone;
	logic      readDone;
	word_t     status;
	word_t     timer;

	////////////////////////////////////////////////////////////////////////////
	// Bus phase FSM

	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			state <= apbIdle;
		else
			state <= nextState;
	end

	always_comb begin
		nextState = state;
		case (state)
			apbIdle:   if (psel && !penable) nextState = apbAccess;  // Setup seen
			apbAccess: begin
				if (!psel || pready)
					nextState = apbIdle;
				else if (stall)
					nextState = apbWait;
			end
			apbWait:   if (!psel || pready) nextState = apbIdle;
			default:   nextState = apbIdle;
		endcase
	end

	assign accessPhase = psel && penable && (state != apbIdle);

	// Address decode
	assign isUartData = (paddr == UART_DATA);
	assign isVector = (paddr[7:4] == IRQ_VECTOR_BASE[7:4]) && (paddr[1:0] == 2'b00)
		&& (paddr[3:2] != 2'b11);   // 0xF0, 0xF4, 0xF8 only

	// Back-pressure from the UART
	assign stall = isUartData && (pwrite ? !uart.txReady : !uart.rxValid);
	assign pready = accessPhase && !stall;

	////////////////////////////////////////////////////////////////////////////
	// Strobes, one cycle, on the completing edge

	assign writeDone = pready && pwrite;
	assign readDone = pready && !pwrite;

	assign uart.txWrite = writeDone && isUartData;
	assign uart.rxRead = readDone && isUartData;   // Clears valid and overrun
	assign dutyWrite = writeDone && (paddr == PWM_DUTY);
	assign enableWrite = writeDone && (paddr == IRQ_ENABLE);
	assign vectorWrite = writeDone && isVector;
	assign vectorIndex = paddr[3:2];

	assign uart.txData = pwdata[7:0];
	assign wdata = pwdata;

	////////////////////////////////////////////////////////////////////////////
	// Read side

	always_comb begin
		status = '0;
		status[STAT_RX_VALID] = uart.rxValid;
		status[STAT_TX_READY] = uart.txReady;
		status[STAT_FRAME_ERROR] = uart.rxFrameError;
		status[STAT_OVERRUN] = uart.rxOverrun;
		status[STAT_PWM] = pwmIrq;
	end

	always_comb begin
		prdata = '0;   // Unmapped reads
		case (paddr)
			UART_DATA:   prdata = {24'h0, uart.rxData};
			UART_STATUS: prdata = status;
			TIMER:       prdata = timer;
			IRQ_ENABLE:  prdata = {29'h0, enable};
			default:     prdata = '0;
		endcase
	end

	// Free-running timer
	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			timer <= '0;
		else
			timer <= timer + 1'b1;
	end

endmodule

`default_nettype wire

/* logic/uartTransmitter.sv */
`timescale 1ns/100ps
`default_nettype none

module uartTransmitter #(
	parameter int divider = 16   // Clocks per bit
) (
	input  logic clk,
	input  logic reset,
	uartIf.tx    uart,
	output logic txd
);

	localparam int divBits = (divider > 1) ? $clog2(divider) : 1;
	localparam logic [divBits-1:0] lastCount = divBits'(divider - 1);

	logic [divBits-1:0] baudCount;
	logic               baudTick;    // Last clock of a bit
	logic [8:0]         shifter;     // Start bit plus data, LSB goes out
	logic [3:0]         bitCount;    // Bits left, zero when idle
	logic               busy;

	assign baudTick = (baudCount == lastCount);

	// Baud divider, restarted by a write so bits line up with the load
	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			baudCount <= '0;
		else if (uart.txWrite || baudTick)
			baudCount <= '0;
		else
			baudCount <= baudCount + 1'b1;
	end

	// Ones shift in behind the data and become the stop bit
	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			shifter <= 9'h1FF;   // Line idles high
		else if (uart.txWrite)
			shifter <= {uart.txData, 1'b0};
		else if (baudTick)
			shifter <= {1'b1, shifter[8:1]};
	end

	// Start, eight data, stop
	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			bitCount <= '0;
		else if (uart.txWrite)
			bitCount <= 4'd10;
		else if (busy && baudTick)
			bitCount <= bitCount - 1'b1;
	end

	assign busy = |bitCount;
	assign uart.txReady = !busy;
	assign txd = shifter[0];

endmodule

`default_nettype wire

/* logic/uartReceiver.sv */
`timescale 1ns/100ps
`default_nettype none

module uartReceiver #(
	parameter int divider = 16   // Clocks per bit
) (
	input  logic clk,
	input  logic reset,
	uartIf.rx    uart,
	input  logic rxd
);

	localparam int divBits = (divider > 1) ? $clog2(divider) : 1;
	localparam logic [divBits-1:0] lastCount = divBits'(divider - 1);
	localparam logic [divBits-1:0] halfCount = divBits'(divider / 2 - 1);

	logic [1:0]         rxSync;      // Two flops against metastability
	logic               rxEdge;
	logic [divBits-1:0] baudCount;
	logic               sampleTick;  // Middle of a bit
	logic [9:0]         shifter;
	logic               frameDone;
	logic [8:0]         rxBuffer;    // Data and stop bit
	logic [1:0]         history;     // {overrun, valid}

	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			rxSync <= 2'b11;
		else
			rxSync <= {rxSync[0], rxd};
	end

	assign rxEdge = rxSync[1] ^ rxSync[0];

	////////////////////////////////////////////////////////////////////////////
	// Bit timing, realigned on every line transition

	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			baudCount <= '0;
		else if (rxEdge || (baudCount == lastCount))
			baudCount <= '0;
		else
			baudCount <= baudCount + 1'b1;
	end

	assign sampleTick = (baudCount == halfCount);

	// Frame is complete once the start bit reaches the LSB
	assign frameDone = !shifter[0];

	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			shifter <= '1;
		else if (frameDone)
			shifter <= '1;   // Rearm for the next start bit
		else if (sampleTick)
			shifter <= {rxSync[1], shifter[9:1]};
	end

	always_ff @(posedge clk) begin
		if (frameDone)
			rxBuffer <= shifter[9:1];
	end

	// A second frame before a read shifts valid into overrun
	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			history <= '0;
		else if (frameDone)
			history <= {history[0], 1'b1};
		else if (uart.rxRead)
			history <= '0;
	end

	assign uart.rxData = rxBuffer[7:0];
	assign uart.rxValid = history[0];
	assign uart.rxOverrun = history[1];
	assign uart.rxFrameError = history[0] && !rxBuffer[8];   // Stop bit seen low

endmodule

`default_nettype wire

/* logic/pwmGenerator.sv */
`timescale 1ns/100ps
`default_nettype none

module pwmGenerator (
	input  logic            clk,
	input  logic            reset,
	input  logic            dutyWrite,
	input  larvaPkg::word_t wdata,
	output logic            pwmOut,
	output logic            pwmIrq
);
	import larvaPkg::*;

	localparam byte_t lastCount = byte_t'(PWM_PERIOD - 1);

	byte_t count;        // 0 .. 179
	byte_t pendingDuty;  // Written by the host
	byte_t activeDuty;   // Used by the comparator
	logic  terminal;
	logic  zeroCount;

	assign terminal = (count == lastCount);
	assign zeroCount = (count == '0);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			count <= '0;
			pendingDuty <= '0;
			activeDuty <= '0;
			pwmOut <= 1'b0;
			pwmIrq <= 1'b0;
		end else begin
			count <= terminal ? '0 : count + 1'b1;
			if (dutyWrite)
				pendingDuty <= wdata[7:0];
			if (terminal)
				activeDuty <= pendingDuty;   // New duty from the next period
			// Compare wins, so duty 0 keeps the pin low
			if (count == activeDuty)
				pwmOut <= 1'b0;
			else if (zeroCount)
				pwmOut <= 1'b1;
			// Flag rises as the count wraps to 0
			if (terminal)
				pwmIrq <= 1'b1;
			else if (dutyWrite)
				pwmIrq <= 1'b0;
		end
	end

endmodule

`default_nettype wire

/* logic/interruptController.sv */
`timescale 1ns/100ps
`default_nettype none

module interruptController (
	input  logic                clk,
	input  logic                reset,
	input  logic                enableWrite,
	input  logic                vectorWrite,
	input  logic [1:0]          vectorIndex,
	input  larvaPkg::word_t     wdata,
	input  larvaPkg::irqLines_t sources,
	output larvaPkg::irqLines_t enable,
	output logic                irq,
	output larvaPkg::vector_t   ivector
);
	import larvaPkg::*;

	vector_t   vectorTable [3];   // One handler address per source
	irqLines_t pending;

	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			enable <= '0;
		else if (enableWrite)
			enable <= irqLines_t'(wdata);
	end

	always_ff @(posedge clk) begin
		if (vectorWrite)
			vectorTable[vectorIndex] <= wdata[31:2];   // Word address only
	end

	assign pending = sources & enable;
	assign irq = |pending;

	////////////////////////////////////////////////////////////////////////////
	// Fixed priority over the raw flags, source 0 first

	always_comb begin
		if (sources[0])
			ivector = vectorTable[0];   // UART rx
		else if (sources[1])
			ivector = vectorTable[1];   // UART tx ready
		else
			ivector = vectorTable[2];   // PWM, also the idle value
	end

endmodule

`default_nettype wire

/* logic/larvaPeripherals.sv */
`timescale 1ns/100ps
`default_nettype none

module larvaPeripherals #(
	parameter int clkFreq  = 24000000,
	parameter int baudRate = 115200
) (
	input  logic              clk,
	input  logic              reset,
	input  logic              psel,
	input  logic              penable,
	input  logic              pwrite,
	input  larvaPkg::ioAddr_t paddr,
	input  larvaPkg::word_t   pwdata,
	output larvaPkg::word_t   prdata,
	output logic              pready,
	input  logic              rxd,
	output logic              txd,
	output logic              pwmOut,
	output logic              irq,
	output larvaPkg::vector_t ivector
);
	import larvaPkg::*;

	// Clocks per bit, rounded to nearest
	localparam int divider = (clkFreq + baudRate / 2) / baudRate;

	logic      pwmIrq;
	logic      dutyWrite;
	logic      enableWrite;
	logic      vectorWrite;
	logic [1:0] vectorIndex;
	word_t     wdata;
	irqLines_t enable;

	uartIf uartBus ();

	apbRegisterControl control (
		.clk        (clk),
		.reset      (reset),
		.psel       (psel),
		.penable    (penable),
		.pwrite     (pwrite),
		.paddr      (paddr),
		.pwdata     (pwdata),
		.prdata     (prdata),
		.pready     (pready),
		.uart       (uartBus.ctrl),
		.pwmIrq     (pwmIrq),
		.dutyWrite  (dutyWrite),
		.enableWrite(enableWrite),
		.vectorWrite(vectorWrite),
		.vectorIndex(vectorIndex),
		.wdata      (wdata),
		.enable     (enable)
	);

	uartTransmitter #(.divider(divider)) transmitter (
		.clk  (clk),
		.reset(reset),
		.uart (uartBus.tx),
		.txd  (txd)
	);

	uartReceiver #(.divider(divider)) receiver (
		.clk  (clk),
		.reset(reset),
		.uart (uartBus.rx),
		.rxd  (rxd)
	);

	pwmGenerator pwm (
		.clk      (clk),
		.reset    (reset),
		.dutyWrite(dutyWrite),
		.wdata    (wdata),
		.pwmOut   (pwmOut),
		.pwmIrq   (pwmIrq)
	);

	// Sources in priority order, rx first
	interruptController interrupts (
		.clk        (clk),
		.reset      (reset),
		.enableWrite(enableWrite),
		.vectorWrite(vectorWrite),
		.vectorIndex(vectorIndex),
		.wdata      (wdata),
		.sources    ({pwmIrq, uartBus.txReady, uartBus.rxValid}),
		.enable     (enable),
		.irq        (irq),
		.ivector    (ivector)
	);

endmodule

`default_nettype wire

/* verif/clockGen.sv */
`timescale 1ns/100ps
`default_nettype none

module clockGen (
	output logic clk,
	output logic reset
);

	localparam int halfPeriod = 10;   // 20 ns clock
	localparam int resetCycles = 4;

	initial begin
		clk = 1'b0;
		forever #halfPeriod clk = ~clk;
	end

	// Reset drops on a falling edge, clear of the sampling edge
	initial begin
		reset = 1'b1;
		repeat (resetCycles) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
	end

endmodule

`default_nettype wire

/* verif/larvaPeripherals_sva.sv */
`timescale 1ns/100ps
`default_nettype none

module larvaPeripheralsChecks (
	input wire logic              clk,
	input wire logic              reset,
	input wire logic              txd,
	input wire logic              txReady,
	input wire logic              psel,
	input wire logic              penable,
	input wire logic              pwrite,
	input wire larvaPkg::ioAddr_t paddr,
	input wire larvaPkg::word_t   pwdata,
	input wire logic              pready,
	input wire logic              irq
);
	import larvaPkg::*;

	int        failureCount = 0;   // Read by the testbench at the end
	irqLines_t enableModel;        // Enable bits as last written over APB

	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			enableModel <= '0;
		else if (psel && penable && pready && pwrite && (paddr == IRQ_ENABLE))
			enableModel <= pwdata[2:0];
	end

	// Idle transmitter keeps the line high
	txIdleHigh: assert property (@(posedge clk) disable iff (reset) txReady |-> txd)
		else begin
			$error("txd low while txReady high");
			failureCount++;
		end

	// Completion needs an access phase right after a setup or a wait cycle
	readyInAccess: assert property (@(posedge clk) disable iff (reset)
		pready |-> (psel && penable && $past(psel && (!penable || !pready))))
		else begin
			$error("pready high outside an access phase");
			failureCount++;
		end

	// Masked sources cannot raise irq
	irqNeedsEnable: assert property (@(posedge clk) disable iff (reset)
		(enableModel == '0) |-> !irq)
		else begin
			$error("irq high with all sources disabled");
			failureCount++;
		end

endmodule

bind larvaPeripherals larvaPeripheralsChecks checks (
	.clk    (clk),
	.reset  (reset),
	.txd    (txd),
	.txReady(uartBus.txReady),
	.psel   (psel),
	.penable(penable),
	.pwrite (pwrite),
	.paddr  (paddr),
	.pwdata (pwdata),
	.pready (pready),
	.irq    (irq)
);

`default_nettype wire

/* verif/larvaPeripheralsTb.sv */
`timescale 1ns/100ps
`default_nettype none

module larvaPeripheralsTb;
	import larvaPkg::*;

	localparam int bitCycles = 16;          // 1 MHz / 62500 baud
	localparam int frameCycles = 10 * bitCycles;
	localparam int periodCycles = 180;
	localparam int frameCount = 12;         // Every frame sent or received, with margin
	localparam int periodCount = 4;
	localparam int timeoutCycles = (3 * (frameCount * frameCycles + periodCount * periodCycles)) / 2;

	logic    clk;
	logic    reset;
	logic    psel;
	logic    penable;
	logic    pwrite;
	ioAddr_t paddr;
	word_t   pwdata;
	word_t   prdata;
	logic    pready;
	logic    rxd;
	logic    txd;
	logic    pwmOut;
	logic    irq;
	vector_t ivector;

	int          errorCount;
	int          checkCount;
	int          lastWaits;     // Wait cycles of the latest transfer
	logic [31:0] lfsrState;

	clockGen clocks (.clk(clk), .reset(reset));

	larvaPeripherals #(.clkFreq(1000000), .baudRate(62500)) uut (
		.clk    (clk),
		.reset  (reset),
		.psel   (psel),
		.penable(penable),
		.pwrite (pwrite),
		.paddr  (paddr),
		.pwdata (pwdata),
		.prdata (prdata),
		.pready (pready),
		.rxd    (rxd),
		.txd    (txd),
		.pwmOut (pwmOut),
		.irq    (irq),
		.ivector(ivector)
	);

	////////////////////////////////////////////////////////////////////////////
	// Helpers

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic nextRandomByte(output byte_t value);
		for (int i = 0; i < 8; i++) begin
			lfsrState = lfsrNext(lfsrState);   // One step per bit
			value[i] = lfsrState[0];
		end
	endtask

	task automatic reportMismatch(input string name, input word_t got, input word_t expected);
		errorCount++;
		$display("ERROR at %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, expected);
	endtask

	// Called on a falling edge, returns on the falling edge after completion
	task automatic apbTransfer(input logic write, input ioAddr_t addr, input word_t data,
		output word_t rdata);
		logic done;
		done = 1'b0;
		rdata = '0;
		psel = 1'b1;            // Setup phase
		penable = 1'b0;
		pwrite = write;
		paddr = addr;
		pwdata = data;
		@(negedge clk);
		penable = 1'b1;
		lastWaits = 0;
		while (!done) begin
			#5;                 // Mid-cycle, well before the rising edge
			if (pready) begin
				rdata = prdata;
				done = 1'b1;
			end else
				lastWaits++;
			@(negedge clk);
		end
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic apbWrite(input ioAddr_t addr, input word_t data);
		word_t unused;
		apbTransfer(1'b1, addr, data, unused);
	endtask

	task automatic apbRead(input ioAddr_t addr, output word_t data);
		apbTransfer(1'b0, addr, 32'h0, data);
	endtask

	// 8N1 frame on rxd, stop bit selectable
	task automatic driveFrame(input byte_t value, input logic stopBit);
		rxd = 1'b0;
		repeat (bitCycles) @(negedge clk);
		for (int i = 0; i < 8; i++) begin
			rxd = value[i];     // LSB first
			repeat (bitCycles) @(negedge clk);
		end
		rxd = stopBit;
		repeat (bitCycles) @(negedge clk);
		rxd = 1'b1;
		repeat (4) @(negedge clk);
	endtask

	task automatic waitPwmRise();
		logic previous;
		logic found;
		found = 1'b0;
		for (int i = 0; i < 2 * periodCycles && !found; i++) begin
			previous = pwmOut;
			@(negedge clk);
			found = !previous && pwmOut;
		end
		if (!found) begin
			errorCount++;
			$display("pwmOut did not rise within two periods");
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Tests

	task automatic testReset();
		word_t rdata;
		checkCount += 3;
		if (txd !== 1'b1) reportMismatch("txd", txd, 1);
		if (pwmOut !== 1'b0) reportMismatch("pwmOut", pwmOut, 0);
		if (irq !== 1'b0) reportMismatch("irq", irq, 0);
		apbRead(UART_STATUS, rdata);
		checkCount++;
		if (rdata !== 32'h2) reportMismatch("status", rdata, 32'h2);   // Only txReady
	endtask

	task automatic testTransmit();
		byte_t value;
		logic  expected;
		word_t rdata;
		nextRandomByte(value);
		apbWrite(UART_DATA, {24'h0, value});
		fork
			begin
				repeat (bitCycles / 2) @(negedge clk);   // Centre of the start bit
				for (int i = 0; i < 10; i++) begin
					expected = (i == 0) ? 1'b0 : (i == 9) ? 1'b1 : value[i - 1];
					checkCount++;
					if (txd !== expected) reportMismatch($sformatf("txd bit %0d", i), txd, expected);
					if (i < 9)
						repeat (bitCycles) @(negedge clk);
				end
			end
			apbWrite(UART_DATA, {24'h0, ~value});   // Stalls behind the first frame
		join
		checkCount++;
		if (lastWaits < frameCycles - 10) begin
			errorCount++;
			$display("Second UART write waited only %0d cycles", lastWaits);
		end
		repeat (frameCycles + 10) @(negedge clk);
		apbRead(UART_STATUS, rdata);
		checkCount++;
		if (rdata[STAT_TX_READY] !== 1'b1) reportMismatch("txReady", rdata[STAT_TX_READY], 1);
	endtask

	task automatic testReceive();
		byte_t first;
		byte_t second;
		byte_t third;
		byte_t bad;
		byte_t late;
		word_t rdata;
		nextRandomByte(first);
		nextRandomByte(second);
		nextRandomByte(third);
		nextRandomByte(bad);
		nextRandomByte(late);
		// Plain frame
		driveFrame(first, 1'b1);
		apbRead(UART_STATUS, rdata);
		checkCount++;
		if ((rdata & 32'hF) !== 32'h3) reportMismatch("status", rdata & 32'hF, 32'h3);
		apbRead(UART_DATA, rdata);
		checkCount++;
		if (rdata !== {24'h0, first}) reportMismatch("rxData", rdata, first);
		// Two frames, no read between
		driveFrame(second, 1'b1);
		driveFrame(third, 1'b1);
		apbRead(UART_STATUS, rdata);
		checkCount++;
		if ((rdata & 32'hF) !== 32'hB) reportMismatch("status", rdata & 32'hF, 32'hB);
		apbRead(UART_DATA, rdata);
		checkCount++;
		if (rdata !== {24'h0, third}) reportMismatch("rxData", rdata, third);
		apbRead(UART_STATUS, rdata);
		checkCount++;
		if ((rdata & 32'hF) !== 32'h2) reportMismatch("status", rdata & 32'hF, 32'h2);
		// Stop bit low
		driveFrame(bad, 1'b0);
		apbRead(UART_STATUS, rdata);
		checkCount++;
		if ((rdata & 32'hF) !== 32'h7) reportMismatch("status", rdata & 32'hF, 32'h7);
		apbRead(UART_DATA, rdata);
		checkCount++;
		if (rdata !== {24'h0, bad}) reportMismatch("rxData", rdata, bad);
		// Read first, frame arrives later
		fork
			apbRead(UART_DATA, rdata);
			begin
				repeat (20) @(negedge clk);
				driveFrame(late, 1'b1);
			end
		join
		checkCount += 2;
		if (rdata !== {24'h0, late}) reportMismatch("rxData", rdata, late);
		if (lastWaits < frameCycles - 10) begin
			errorCount++;
			$display("Empty UART read waited only %0d cycles", lastWaits);
		end
	endtask

	task automatic testPwm();
		int    highCount;
		word_t rdata;
		apbWrite(PWM_DUTY, 32'd50);
		waitPwmRise();          // First period with the new duty
		waitPwmRise();
		highCount = 0;
		repeat (periodCycles) begin
			if (pwmOut)
				highCount++;
			@(negedge clk);
		end
		checkCount++;
		if (highCount != 50) reportMismatch("pwmOut high cycles", highCount, 50);
		apbRead(UART_STATUS, rdata);
		checkCount++;
		if (rdata[STAT_PWM] !== 1'b1) reportMismatch("pwm flag", rdata[STAT_PWM], 1);
		apbWrite(PWM_DUTY, 32'd50);   // Clears the flag
		apbRead(UART_STATUS, rdata);
		checkCount++;
		if (rdata[STAT_PWM] !== 1'b0) reportMismatch("pwm flag", rdata[STAT_PWM], 0);
	endtask

	task automatic testInterrupts();
		word_t vectors [3];
		word_t rdata;
		byte_t value;
		vectors[0] = 32'h0000_0100;
		vectors[1] = 32'h0000_0240;
		vectors[2] = 32'h0000_0388;
		for (int i = 0; i < 3; i++)
			apbWrite(IRQ_VECTOR_BASE + ioAddr_t'(4 * i), vectors[i]);
		apbWrite(IRQ_ENABLE, 32'b110);
		apbRead(IRQ_ENABLE, rdata);
		checkCount++;
		if (rdata !== 32'b110) reportMismatch("enable", rdata, 32'b110);
		checkCount += 2;
		if (irq !== 1'b1) reportMismatch("irq", irq, 1);
		if (ivector !== vectors[1][31:2]) reportMismatch("ivector", ivector, vectors[1][31:2]);
		// Receive flag outranks tx ready in the vector
		nextRandomByte(value);
		driveFrame(value, 1'b1);
		checkCount += 2;
		if (irq !== 1'b1) reportMismatch("irq", irq, 1);
		if (ivector !== vectors[0][31:2]) reportMismatch("ivector", ivector, vectors[0][31:2]);
		apbRead(UART_DATA, rdata);
		checkCount++;
		if (rdata !== {24'h0, value}) reportMismatch("rxData", rdata, value);
		apbWrite(IRQ_ENABLE, 32'b000);
		checkCount++;
		if (irq !== 1'b0) reportMismatch("irq", irq, 0);
		apbRead(IRQ_ENABLE, rdata);
		checkCount++;
		if (rdata !== 32'h0) reportMismatch("enable", rdata, 0);
	endtask

	task automatic testTimer();
		word_t first;
		word_t second;
		apbRead(TIMER, first);
		apbRead(TIMER, second);    // Setup follows the first completion at once
		checkCount++;
		if (second - first !== 32'd2) reportMismatch("timer delta", second - first, 2);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Sequence

	initial begin
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		rxd = 1'b1;            // Idle line
		errorCount = 0;
		checkCount = 0;
		lastWaits = 0;
		lfsrState = 32'h2984_e8b9;
		@(negedge reset);
		@(negedge clk);
		testReset();
		testTransmit();
		testReceive();
		testPwm();
		testInterrupts();
		testTimer();
		errorCount += uut.checks.failureCount;
		$display("Errors: %0d, checks: %0d", errorCount, checkCount);
		if (errorCount == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

	// Watchdog
	initial begin
		repeat (timeoutCycles) @(posedge clk);
		$display("Run did not finish within %0d cycles", timeoutCycles);
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* files.f */
logic/larvaPkg.sv
logic/uartIf.sv
logic/apbRegisterControl.sv
logic/uartTransmitter.sv
logic/uartReceiver.sv
logic/pwmGenerator.sv
logic/interruptController.sv
logic/larvaPeripherals.sv
verif/clockGen.sv
verif/larvaPeripherals_sva.sv
verif/larvaPeripheralsTb.sv

/* Makefile */
TOP = larvaPeripheralsTb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f files.f -o sim

run: compile
	@out="$$(./obj_dir/sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf obj_dir
